/* src.f */
hdl/as6d_app_pkg.sv
hdl/multiple_value_comparator.sv
hdl/as6d_app_pipe_rdy_monitor.sv
hdl/as6d_app_pipe_sch_concat_line_interleaved.sv
hdl/as6d_app_bpg.sv
hdl/as6d_app_pipe_sch_top.sv
tests/as6d_app_pipe_sch_checker.sv
tests/tb_as6d_app_pipe_sch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_as6d_app_pipe_sch
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_as6d_app_pipe_sch.sv */
`timescale 1ns/1ps

module tb_as6d_app_pipe_sch
    import as6d_app_pkg::*;
();

    localparam int NUM_ROWS    = 7;
    localparam int MAX_REC     = 64;
    localparam int WATCHDOG_NS = NUM_ROWS * 300 * 4;

    typedef struct packed {
        aggre_mode_t  mode;
        pipe_bitmap_t en;
        pipe_idx_t    master;
        pipe_bitmap_t mask;
        datatype_t    dt0;
        datatype_t    dt1;
        datatype_t    dt2;
        datatype_t    dt3;
        count_t       frame;
        count_t       line;
        datatype_t    pkt_dt;
        logic [15:0]  exp_seq;    // One granted pipe per nibble with the first grant lowest
        int           exp_num;
        logic         exp_fail;
    } row_t;

    logic         aggre_clk;
    logic         aggre_clk_rst_n;
    aggre_mode_t  aggre_mode;
    pipe_bitmap_t pipe_concat_en;
    pipe_idx_t    master_pipe;
    pipe_bitmap_t pipe_mask_bitmap;
    pipe_bitmap_t pipe_line_vld;
    count_t       pipe_framecount;
    count_t       pipe_linecount;
    datatype_t    pipe_pkt_datatype;
    pipe_bitmap_t dt_align_vld;
    datatype_t    dt_align0;
    datatype_t    dt_align1;
    datatype_t    dt_align2;
    datatype_t    dt_align3;
    pipe_bitmap_t ack;
    pipe_bitmap_t line_end;
    logic         start_sch_pulse;
    logic         end_sch_pulse;
    logic         align_fail_pulse;
    pipe_bitmap_t up_state_concat;
    logic         bpg_up_state;
    count_t       bpg_framecount;
    count_t       bpg_linecount;
    datatype_t    bpg_pkt_datatype;
    logic         sch_data_type_align_fail_int;

    row_t         rows [NUM_ROWS];
    pipe_bitmap_t rec_map [MAX_REC];    // Grants seen at the ports in order
    logic         rec_bpg [MAX_REC];
    int           n_rec      = 0;
    int           n_end      = 0;
    int           cur_row    = 0;
    int           value_errs = 0;
    int           other_errs = 0;
    integer       seed       = 32'h24dc7f7c;

    as6d_app_pipe_sch_top uut (.*);

    bind as6d_app_pipe_sch_top as6d_app_pipe_sch_checker u_checker (
        .aggre_clk        (aggre_clk),
        .aggre_clk_rst_n  (aggre_clk_rst_n),
        .up_state_concat  (up_state_concat),
        .bpg_up_state     (bpg_up_state),
        .pipe_mask_bitmap (pipe_mask_bitmap),
        .start_sch_pulse  (start_sch_pulse),
        .end_sch_pulse    (end_sch_pulse),
        .align_fail_pulse (align_fail_pulse)
    );

    initial aggre_clk = 1'b0;
    always #2 aggre_clk = ~aggre_clk;

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_bitmap(input string name, input pipe_bitmap_t got,
                                input pipe_bitmap_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input pipe_idx_t got, input pipe_idx_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_dtype(input string name, input datatype_t got, input datatype_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    function automatic pipe_idx_t onehot_to_idx(input pipe_bitmap_t map);
        pipe_idx_t idx;
        idx = '0;
        for (int i = 0; i < PIPE_NUM; i++) begin
            if (map[i]) begin
                idx = pipe_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ==================================================
    // Pipe response model and port recorder
    // ==================================================
    initial begin : pipe_model
        pipe_idx_t gnt_idx;
        int        dly;
        ack      = '0;
        line_end = '0;
        forever begin
            @(negedge aggre_clk);
            if (|up_state_concat) begin
                gnt_idx = onehot_to_idx(up_state_concat);
                dly     = 1 + int'({$random(seed)} % 32'd4);   // 1 to 4 cycles
                repeat (dly) @(negedge aggre_clk);
                ack[gnt_idx] = 1'b1;
                @(negedge aggre_clk);
                ack = '0;
                repeat (2) @(negedge aggre_clk);
                line_end[gnt_idx] = 1'b1;       // 3 cycles after ack
                @(negedge aggre_clk);
                line_end = '0;
            end
        end
    end

    initial begin : grant_recorder
        logic [PIPE_NUM:0] grant_now;
        logic [PIPE_NUM:0] grant_prev;
        grant_prev = '0;
        forever begin
            @(negedge aggre_clk);
            grant_now = {bpg_up_state, up_state_concat};
            if ((grant_now != '0) && (grant_prev == '0) && (n_rec < MAX_REC)) begin
                rec_map[n_rec] = up_state_concat;
                rec_bpg[n_rec] = bpg_up_state;
                n_rec++;
            end
            if (end_sch_pulse) begin
                n_end++;
            end
            grant_prev = grant_now;
        end
    end

    // ==================================================
    // One table row
    // ==================================================
    task automatic run_row(input int r);
        int        last;
        int        rec_base;
        int        end_base;
        pipe_idx_t exp_idx;
        logic      exp_int;
        last     = 0;
        rec_base = n_rec;
        end_base = n_end;
        exp_int  = rows[r].exp_fail && (rows[r].mode == AGGRE_MODE_CONCAT);
        aggre_mode        = rows[r].mode;
        pipe_concat_en    = rows[r].en;
        master_pipe       = rows[r].master;
        pipe_mask_bitmap  = rows[r].mask;
        dt_align0         = rows[r].dt0;
        dt_align1         = rows[r].dt1;
        dt_align2         = rows[r].dt2;
        dt_align3         = rows[r].dt3;
        pipe_framecount   = rows[r].frame;
        pipe_linecount    = rows[r].line;
        pipe_pkt_datatype = rows[r].pkt_dt;
        @(negedge aggre_clk);
        for (int i = 0; i < PIPE_NUM; i++) begin
            if (rows[r].en[i]) begin
                last = i;
            end
        end
        // One ready strobe per cycle
        for (int i = 0; i < PIPE_NUM; i++) begin
            if (rows[r].en[i]) begin
                pipe_line_vld = pipe_bitmap_t'(1 << i);
                @(negedge aggre_clk);
                pipe_line_vld = '0;
                check_flag("start_sch_pulse", start_sch_pulse, i == last);
            end
        end
        @(negedge aggre_clk);
        check_flag("align_fail_pulse", align_fail_pulse, rows[r].exp_fail);
        check_flag("sch_data_type_align_fail_int", sch_data_type_align_fail_int, exp_int);
        check_flag("early grant", |{bpg_up_state, up_state_concat}, 1'b0);
        pipe_framecount   = ~rows[r].frame;     // Header moves on after the lock
        pipe_linecount    = ~rows[r].line;
        pipe_pkt_datatype = ~rows[r].pkt_dt;
        if (rows[r].exp_fail) begin
            repeat (10) @(negedge aggre_clk);
        end else begin
            @(negedge aggre_clk);
            check_flag("master grant", |{bpg_up_state, up_state_concat}, 1'b1);
            if (!rows[r].mask[rows[r].master]) begin
                check_idx("master grant", onehot_to_idx(up_state_concat), rows[r].master);
            end
            while (!end_sch_pulse) begin
                @(negedge aggre_clk);
            end
        end
        repeat (2) @(negedge aggre_clk);
        check_count("bpg_framecount", bpg_framecount, rows[r].frame);
        check_count("bpg_linecount", bpg_linecount, rows[r].line);
        check_dtype("bpg_pkt_datatype", bpg_pkt_datatype, rows[r].pkt_dt);
        if ((n_end - end_base) != (rows[r].exp_fail ? 0 : 1)) begin
            other_errs++;
            $display("Row %0d: end of schedule signalled %0d times", r, n_end - end_base);
        end
        if ((n_rec - rec_base) != rows[r].exp_num) begin
            other_errs++;
            $display("Row %0d: %0d grants seen, %0d expected", r, n_rec - rec_base,
                     rows[r].exp_num);
        end else begin
            for (int k = 0; k < rows[r].exp_num; k++) begin
                exp_idx = rows[r].exp_seq[4*k +: 2];
                check_flag("bpg_up_state", rec_bpg[rec_base + k], rows[r].mask[exp_idx]);
                if (rows[r].mask[exp_idx]) begin
                    check_bitmap("up_state_concat", rec_map[rec_base + k], '0);
                end else begin
                    check_bitmap("up_state_concat", rec_map[rec_base + k],
                                 pipe_bitmap_t'(4'b0001 << exp_idx));
                end
            end
        end
        repeat (2) @(negedge aggre_clk);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before all table rows finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        aggre_clk_rst_n   = 1'b0;
        aggre_mode        = '0;
        pipe_concat_en    = '0;
        master_pipe       = '0;
        pipe_mask_bitmap  = '0;
        pipe_line_vld     = '0;
        pipe_framecount   = '0;
        pipe_linecount    = '0;
        pipe_pkt_datatype = '0;
        dt_align_vld      = 4'hf;
        dt_align0         = '0;
        dt_align1         = '0;
        dt_align2         = '0;
        dt_align3         = '0;

        // mode, en, master, mask, dt0..dt3, frame, line, pkt dt, sequence, count, fail
        rows[0] = '{2'd1, 4'hf, 2'd0, 4'h0, 6'h2b, 6'h2b, 6'h2b, 6'h2b,
                    16'h0001, 16'h0010, 6'h2b, 16'h3210, 4, 1'b0};
        rows[1] = '{2'd1, 4'hf, 2'd2, 4'h0, 6'h2b, 6'h2b, 6'h2b, 6'h2b,
                    16'h0002, 16'h0011, 6'h2b, 16'h1032, 4, 1'b0};
        rows[2] = '{2'd1, 4'hb, 2'd3, 4'h2, 6'h1e, 6'h1e, 6'h00, 6'h1e,
                    16'h0003, 16'h0012, 6'h1e, 16'h0103, 3, 1'b0};
        rows[3] = '{2'd1, 4'hf, 2'd0, 4'h0, 6'h2b, 6'h2b, 6'h2c, 6'h2b,
                    16'h0004, 16'h0013, 6'h2b, 16'h0000, 0, 1'b1};
        rows[4] = '{2'd2, 4'h6, 2'd1, 4'h0, 6'h24, 6'h24, 6'h2a, 6'h24,
                    16'h0005, 16'h0014, 6'h24, 16'h0000, 0, 1'b1};
        rows[5] = '{2'd0, 4'h5, 2'd2, 4'h5, 6'h24, 6'h3f, 6'h24, 6'h12,
                    16'hbeef, 16'h0015, 6'h24, 16'h0002, 2, 1'b0};
        rows[6] = '{2'd1, 4'he, 2'd1, 4'h8, 6'h2b, 6'h2b, 6'h2b, 6'h2b,
                    16'h0007, 16'ha5a5, 6'h2b, 16'h0321, 3, 1'b0};

        repeat (3) @(negedge aggre_clk);
        aggre_clk_rst_n = 1'b1;
        repeat (2) @(negedge aggre_clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_row = r;
            run_row(r);
        end

        $display("Check summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if ((value_errs + other_errs) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tests/as6d_app_pipe_sch_checker.sv */
`timescale 1ns/1ps

module as6d_app_pipe_sch_checker
    import as6d_app_pkg::*;
(
    input  logic         aggre_clk,
    input  logic         aggre_clk_rst_n,
    input  pipe_bitmap_t up_state_concat,
    input  logic         bpg_up_state,
    input  pipe_bitmap_t pipe_mask_bitmap,
    input  logic         start_sch_pulse,
    input  logic         end_sch_pulse,
    input  logic         align_fail_pulse
);

    logic sch_active;   // Between a start and its ending pulse

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_active <= 1'b0;
        end else if (start_sch_pulse) begin
            sch_active <= 1'b1;
        end else if (end_sch_pulse || align_fail_pulse) begin
            sch_active <= 1'b0;
        end
    end

    // ==================================================
    // Grant properties
    // ==================================================
    a_single_grant: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $onehot0({bpg_up_state, up_state_concat}))
        else $error("more than one grant high at once");

    a_no_masked_concat: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        (up_state_concat & pipe_mask_bitmap) == '0)
        else $error("masked pipe granted on up_state_concat");

    a_end_single: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        end_sch_pulse |=> !end_sch_pulse)
        else $error("end_sch_pulse longer than one cycle");

    // Idle scheduler drives no grant
    a_idle_no_grant: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        !sch_active |-> ((up_state_concat == '0) && !bpg_up_state))
        else $error("grant high while scheduler idle");

endmodule

/* hdl/as6d_app_pipe_sch_top.sv */
`timescale 1ns/1ps

module as6d_app_pipe_sch_top
    import as6d_app_pkg::*;
(
    input  logic         aggre_clk,
    input  logic         aggre_clk_rst_n,

    input  aggre_mode_t  aggre_mode,
    input  pipe_bitmap_t pipe_concat_en,
    input  pipe_idx_t    master_pipe,
    input  pipe_bitmap_t pipe_mask_bitmap,

    input  pipe_bitmap_t pipe_line_vld,

    input  count_t       pipe_framecount,
    input  count_t       pipe_linecount,
    input  datatype_t    pipe_pkt_datatype,

    input  pipe_bitmap_t dt_align_vld,
    input  datatype_t    dt_align0,
    input  datatype_t    dt_align1,
    input  datatype_t    dt_align2,
    input  datatype_t    dt_align3,

    input  pipe_bitmap_t ack,
    input  pipe_bitmap_t line_end,

    output logic         start_sch_pulse,
    output logic         end_sch_pulse,
    output logic         align_fail_pulse,
    output pipe_bitmap_t up_state_concat,
    output logic         bpg_up_state,
    output count_t       bpg_framecount,
    output count_t       bpg_linecount,
    output datatype_t    bpg_pkt_datatype,
    output logic         sch_data_type_align_fail_int
);

    pipe_bitmap_t pipe_rdy_bitmap;
    logic         bpg_ack;
    logic         bpg_line_end;

    // ==================================================
    // Readiness, scheduling, blank pattern
    // ==================================================
    as6d_app_pipe_rdy_monitor u_rdy_monitor (
        .aggre_clk        (aggre_clk),
        .aggre_clk_rst_n  (aggre_clk_rst_n),
        .pipe_concat_en   (pipe_concat_en),
        .pipe_line_vld    (pipe_line_vld),
        .end_sch_pulse    (end_sch_pulse),
        .align_fail_pulse (align_fail_pulse),
        .pipe_rdy_bitmap  (pipe_rdy_bitmap),
        .start_sch_pulse  (start_sch_pulse)
    );

    as6d_app_pipe_sch_concat_line_interleaved u_sch (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .aggre_mode                   (aggre_mode),
        .pipe_concat_en               (pipe_concat_en),
        .master_pipe                  (master_pipe),
        .pipe_mask_bitmap             (pipe_mask_bitmap),
        .pipe_rdy_bitmap              (pipe_rdy_bitmap),
        .pipe_framecount              (pipe_framecount),
        .pipe_linecount               (pipe_linecount),
        .pipe_pkt_datatype            (pipe_pkt_datatype),
        .start_sch_pulse              (start_sch_pulse),
        .end_sch_pulse                (end_sch_pulse),
        .align_fail_pulse             (align_fail_pulse),
        .dt_align_vld                 (dt_align_vld),
        .dt_align0                    (dt_align0),
        .dt_align1                    (dt_align1),
        .dt_align2                    (dt_align2),
        .dt_align3                    (dt_align3),
        .ack                          (ack),
        .line_end                     (line_end),
        .bpg_ack                      (bpg_ack),
        .bpg_line_end                 (bpg_line_end),
        .bpg_framecount               (bpg_framecount),
        .bpg_linecount                (bpg_linecount),
        .bpg_pkt_datatype             (bpg_pkt_datatype),
        .bpg_up_state                 (bpg_up_state),
        .up_state_concat              (up_state_concat),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    // Answers for masked pipes
    as6d_app_bpg u_bpg (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .bpg_up_state    (bpg_up_state),
        .bpg_ack         (bpg_ack),
        .bpg_line_end    (bpg_line_end)
    );

endmodule

/* hdl/as6d_app_bpg.sv */
`timescale 1ns/1ps

module as6d_app_bpg
    import as6d_app_pkg::*;
(
    input  logic aggre_clk,
    input  logic aggre_clk_rst_n,
    input  logic bpg_up_state,
    output logic bpg_ack,
    output logic bpg_line_end
);

    bpg_state_t           bpg_cs;
    logic                 up_state_d;
    logic                 up_rise;
    logic [BPG_CNT_W-1:0] cnt;

    assign up_rise = bpg_up_state && !up_state_d;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            up_state_d <= 1'b0;
        end else begin
            up_state_d <= bpg_up_state;
        end
    end

    // ==================================================
    // Ack delay, then blank pixel count
    // ==================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            bpg_cs       <= BPG_IDLE;
            cnt          <= '0;
            bpg_ack      <= 1'b0;
            bpg_line_end <= 1'b0;
        end else begin
            bpg_ack      <= 1'b0;
            bpg_line_end <= 1'b0;
            case (bpg_cs)
                BPG_IDLE: begin
                    if (up_rise) begin
                        bpg_cs <= BPG_WAIT_ACK;
                        cnt    <= BPG_CNT_W'(BPG_ACK_DLY - 2);
                    end
                end
                BPG_WAIT_ACK: begin
                    if (cnt == '0) begin
                        bpg_ack <= 1'b1;
                        bpg_cs  <= BPG_LINE;
                        cnt     <= BPG_CNT_W'(BPG_LINE_LEN - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                BPG_LINE: begin
                    if (cnt == '0) begin
                        bpg_line_end <= 1'b1;   // Last blank pixel
                        bpg_cs       <= BPG_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: bpg_cs <= BPG_IDLE;
            endcase
        end
    end

endmodule

/* hdl/as6d_app_pipe_sch_concat_line_interleaved.sv */
`timescale 1ns/1ps

module as6d_app_pipe_sch_concat_line_interleaved
    import as6d_app_pkg::*;
(
    input  logic         aggre_clk,
    input  logic         aggre_clk_rst_n,

    input  aggre_mode_t  aggre_mode,
    input  pipe_bitmap_t pipe_concat_en,
    input  pipe_idx_t    master_pipe,
    input  pipe_bitmap_t pipe_mask_bitmap,
    input  pipe_bitmap_t pipe_rdy_bitmap,

    input  count_t       pipe_framecount,
    input  count_t       pipe_linecount,
    input  datatype_t    pipe_pkt_datatype,

    input  logic         start_sch_pulse,
    output logic         end_sch_pulse,
    output logic         align_fail_pulse,

    input  pipe_bitmap_t dt_align_vld,
    input  datatype_t    dt_align0,
    input  datatype_t    dt_align1,
    input  datatype_t    dt_align2,
    input  datatype_t    dt_align3,

    input  pipe_bitmap_t ack,
    input  pipe_bitmap_t line_end,

    input  logic         bpg_ack,
    input  logic         bpg_line_end,
    output count_t       bpg_framecount,
    output count_t       bpg_linecount,
    output datatype_t    bpg_pkt_datatype,
    output logic         bpg_up_state,

    output pipe_bitmap_t up_state_concat,
    output logic         sch_data_type_align_fail_int
);

    sch_state_t   sch_cs;
    sch_state_t   sch_ns;

    pipe_bitmap_t cmp_vld;
    logic         out_comp_fail;
    logic         start_ok;

    // Order table, slot 0 is served first
    pipe_bitmap_t slot_vld;
    pipe_idx_t    slot_idx [PIPE_NUM];
    pipe_bitmap_t rot_vld;
    pipe_idx_t    rot_idx  [PIPE_NUM];
    pipe_idx_t    first_slot;
    pipe_idx_t    rot_slot;
    pipe_idx_t    order;

    logic         master_flag;
    logic         gnt;
    pipe_idx_t    cur_idx;           // Pipe holding the line slot
    pipe_bitmap_t up_state_int;
    logic         ack_hit;
    logic         line_end_hit;
    logic         ack_rotate;

    // ==================================================
    // Data type alignment check
    // ==================================================
    assign cmp_vld = {PIPE_NUM{start_sch_pulse}} & pipe_rdy_bitmap & dt_align_vld;

    multiple_value_comparator u_multiple_value_comparator (
        .in_vld        (cmp_vld),
        .in_data0      (dt_align0),
        .in_data1      (dt_align1),
        .in_data2      (dt_align2),
        .in_data3      (dt_align3),
        .out_comp_fail (out_comp_fail)
    );

    assign start_ok = start_sch_pulse && !out_comp_fail && (sch_cs == SCH_SILENT);

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            align_fail_pulse <= 1'b0;
        end else begin
            align_fail_pulse <= out_comp_fail;   // Only valid on start
        end
    end

    // Status reflects the latest start
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_data_type_align_fail_int <= 1'b0;
        end else if (start_sch_pulse) begin
            sch_data_type_align_fail_int <= (aggre_mode == AGGRE_MODE_CONCAT) && out_comp_fail;
        end
    end

    // Header lock for the BPG
    always_ff @(posedge aggre_clk) begin
        if (start_sch_pulse) begin
            bpg_framecount   <= pipe_framecount;
            bpg_linecount    <= pipe_linecount;
            bpg_pkt_datatype <= pipe_pkt_datatype;
        end
    end

    // ==================================================
    // BPG mux
    // ==================================================
    assign ack_hit      = pipe_mask_bitmap[cur_idx] ? bpg_ack : ack[cur_idx];
    assign line_end_hit = pipe_mask_bitmap[cur_idx] ? bpg_line_end : line_end[cur_idx];

    always_comb begin
        up_state_int          = '0;
        up_state_int[cur_idx] = gnt;
    end

    assign up_state_concat = up_state_int & ~pipe_mask_bitmap;
    assign bpg_up_state    = |(up_state_int & pipe_mask_bitmap);

    // ==================================================
    // Order table rotation
    // ==================================================
    // Lowest valid slot
    always_comb begin
        first_slot = '0;
        for (int i = PIPE_NUM - 1; i >= 0; i--) begin
            if (slot_vld[i]) begin
                first_slot = pipe_idx_t'(i);
            end
        end
    end

    assign order      = slot_idx[first_slot];
    assign rot_slot   = master_flag ? master_pipe : first_slot;
    assign ack_rotate = (sch_cs == SCH_WAIT_ACK) && ack_hit;

    // Served slot goes to the back, invalidated
    always_comb begin
        for (int s = 0; s < PIPE_NUM - 1; s++) begin
            rot_vld[s] = slot_vld[rot_slot + pipe_idx_t'(s + 1)];
            rot_idx[s] = slot_idx[rot_slot + pipe_idx_t'(s + 1)];
        end
        rot_vld[PIPE_NUM-1] = 1'b0;
        rot_idx[PIPE_NUM-1] = slot_idx[rot_slot];
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            slot_vld <= '0;
            for (int i = 0; i < PIPE_NUM; i++) begin
                slot_idx[i] <= '0;
            end
        end else if (start_ok) begin
            slot_vld <= pipe_concat_en;
            for (int i = 0; i < PIPE_NUM; i++) begin
                slot_idx[i] <= pipe_idx_t'(i);
            end
        end else if (ack_rotate) begin
            slot_vld <= rot_vld;
            slot_idx <= rot_idx;
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_flag <= 1'b0;
        end else if (sch_cs == SCH_MASTER) begin
            master_flag <= 1'b1;
        end else if (ack_rotate) begin
            master_flag <= 1'b0;
        end
    end

    // ==================================================
    // Scheduling FSM
    // ==================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_cs <= SCH_SILENT;
        end else begin
            sch_cs <= sch_ns;
        end
    end

    always_comb begin
        sch_ns = sch_cs;
        case (sch_cs)
            SCH_SILENT:        if (start_ok) sch_ns = SCH_START_CONCAT;
            SCH_START_CONCAT:  sch_ns = SCH_MASTER;
            SCH_MASTER:        sch_ns = SCH_WAIT_ACK;
            SCH_ORDER:         sch_ns = SCH_WAIT_ACK;
            SCH_WAIT_ACK:      if (ack_hit) sch_ns = SCH_CLEAR_STATE;
            SCH_CLEAR_STATE:   sch_ns = SCH_WAIT_LINE_END;
            SCH_WAIT_LINE_END: begin
                if (line_end_hit) begin
                    sch_ns = (|slot_vld) ? SCH_ORDER : SCH_SILENT;
                end
            end
            default:           sch_ns = SCH_SILENT;
        endcase
    end

    // Grant register, one pipe at a time
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            gnt     <= 1'b0;
            cur_idx <= '0;
        end else if (sch_ns == SCH_MASTER) begin
            gnt     <= 1'b1;
            cur_idx <= master_pipe;
        end else if (sch_ns == SCH_ORDER) begin
            gnt     <= 1'b1;
            cur_idx <= order;
        end else if (ack_rotate) begin
            gnt     <= 1'b0;                    // Drops the cycle after ack
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            end_sch_pulse <= 1'b0;
        end else begin
            end_sch_pulse <= (sch_cs == SCH_WAIT_LINE_END) && (sch_ns == SCH_SILENT);
        end
    end

endmodule

/* hdl/as6d_app_pipe_rdy_monitor.sv */
`timescale 1ns/1ps

module as6d_app_pipe_rdy_monitor
    import as6d_app_pkg::*;
(
    input  logic         aggre_clk,
    input  logic         aggre_clk_rst_n,
    input  pipe_bitmap_t pipe_concat_en,
    input  pipe_bitmap_t pipe_line_vld,     // Line header ready strobes
    input  logic         end_sch_pulse,
    input  logic         align_fail_pulse,
    output pipe_bitmap_t pipe_rdy_bitmap,
    output logic         start_sch_pulse
);

    logic         idle;
    logic         rearm;
    logic         all_rdy;
    pipe_bitmap_t rdy_next;

    assign rearm    = end_sch_pulse | align_fail_pulse;
    assign rdy_next = pipe_rdy_bitmap | pipe_line_vld;

    // Enabled set fully covered, counting this cycle's strobes
    assign all_rdy = (|pipe_concat_en) &&
                     ((rdy_next & pipe_concat_en) == pipe_concat_en);

    // ==================================================
    // Sticky ready bits
    // ==================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            pipe_rdy_bitmap <= '0;
        end else if (rearm) begin
            pipe_rdy_bitmap <= '0;
        end else if (idle) begin
            pipe_rdy_bitmap <= rdy_next;    // Frozen while a schedule runs
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            idle <= 1'b1;
        end else if (rearm) begin
            idle <= 1'b1;
        end else if (idle && all_rdy) begin
            idle <= 1'b0;
        end
    end

    // Single cycle, idle drops on the same edge
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            start_sch_pulse <= 1'b0;
        end else begin
            start_sch_pulse <= idle && all_rdy && !rearm;
        end
    end

endmodule

/* hdl/multiple_value_comparator.sv */
`timescale 1ns/1ps

module multiple_value_comparator
    import as6d_app_pkg::*;
(
    input  pipe_bitmap_t in_vld,
    input  datatype_t    in_data0,
    input  datatype_t    in_data1,
    input  datatype_t    in_data2,
    input  datatype_t    in_data3,
    output logic         out_comp_fail
);

    datatype_t data_arr [PIPE_NUM];

    assign data_arr[0] = in_data0;
    assign data_arr[1] = in_data1;
    assign data_arr[2] = in_data2;
    assign data_arr[3] = in_data3;

    // ==================================================
    // Pairwise compare over the valid inputs
    // ==================================================
    // With one valid input or none, no pair qualifies
    always_comb begin
        out_comp_fail = 1'b0;
        for (int i = 0; i < PIPE_NUM - 1; i++) begin
            for (int j = i + 1; j < PIPE_NUM; j++) begin
                if (in_vld[i] && in_vld[j] && (data_arr[i] != data_arr[j])) begin
                    out_comp_fail = 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/as6d_app_pkg.sv */
package as6d_app_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int PIPE_NUM   = 4;
    localparam int PIPE_IDX_W = 2;
    localparam int DT_W       = 6;
    localparam int CNT_W      = 16;
    localparam int MODE_W     = 2;

    typedef logic [PIPE_NUM-1:0]   pipe_bitmap_t;  // One bit per pipe
    typedef logic [PIPE_IDX_W-1:0] pipe_idx_t;
    typedef logic [DT_W-1:0]       datatype_t;     // CSI data type
    typedef logic [CNT_W-1:0]      count_t;        // Frame or line count
    typedef logic [MODE_W-1:0]     aggre_mode_t;

    // Mode in which a data type mismatch reaches the status flag
    localparam aggre_mode_t AGGRE_MODE_CONCAT = 2'd1;

    // ==================================================
    // Blank pattern generator timing
    // ==================================================
    localparam int BPG_ACK_DLY  = 2;  // Grant rise to ack
    localparam int BPG_LINE_LEN = 6;  // Ack to line end
    localparam int BPG_CNT_W    = 3;

    // Scheduler FSM
    typedef enum logic [2:0] {
        SCH_SILENT        = 3'd0,
        SCH_START_CONCAT  = 3'd1,
        SCH_MASTER        = 3'd2,
        SCH_ORDER         = 3'd3,
        SCH_WAIT_ACK      = 3'd4,
        SCH_CLEAR_STATE   = 3'd5,
        SCH_WAIT_LINE_END = 3'd6
    } sch_state_t;

    typedef enum logic [1:0] {
        BPG_IDLE     = 2'd0,
        BPG_WAIT_ACK = 2'd1,
        BPG_LINE     = 2'd2
    } bpg_state_t;

endpackage
